/* Makefile */
VERILATOR ?= verilator
TOP       ?= ht_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# Pass or fail is decided from the simulation output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(BUILD_DIR)

/* common/ht_cfg_pkg.sv */
package ht_cfg_pkg;

  localparam int KEY_WIDTH    = 32;
  localparam int VALUE_WIDTH  = 16;

  // 256 buckets.
  localparam int BUCKET_WIDTH = 8;

  // 16 entries in the data RAM.
  localparam int PTR_WIDTH    = 4;

  // Head table word is the chain head pointer plus its valid flag.
  localparam int HEAD_WIDTH   = PTR_WIDTH + 1;

  typedef struct packed {
    logic [KEY_WIDTH-1:0]   key;
    logic [VALUE_WIDTH-1:0] value;
    logic [PTR_WIDTH-1:0]   next_ptr;
    logic                   next_ptr_val;
  } ht_entry_t;

  localparam int ENTRY_WIDTH  = $bits(ht_entry_t);

endpackage

/* common/ht_ifs.sv */
`timescale 1ns/1ns

// Command stream between pipeline stages.
interface ht_if
  import ht_cfg_pkg::*, ht_ops_pkg::*;
();

  ht_opcode_t              opcode;
  logic [KEY_WIDTH-1:0]    key;
  logic [VALUE_WIDTH-1:0]  value;
  logic [BUCKET_WIDTH-1:0] bucket;
  logic [PTR_WIDTH-1:0]    head_ptr;
  logic                    head_ptr_val;
  logic                    valid;
  logic                    ready;

  modport master (
    output opcode, key, value, bucket, head_ptr, head_ptr_val, valid,
    input  ready
  );

  modport slave (
    input  opcode, key, value, bucket, head_ptr, head_ptr_val, valid,
    output ready
  );

endinterface

// Result stream out of the data table.
interface ht_res_if
  import ht_cfg_pkg::*, ht_ops_pkg::*;
();

  ht_result_t             result;
  logic [KEY_WIDTH-1:0]   key;
  logic [VALUE_WIDTH-1:0] value;
  logic                   valid;
  logic                   ready;

  modport master (
    output result, key, value, valid,
    input  ready
  );

  modport slave (
    input  result, key, value, valid,
    output ready
  );

endinterface

// New chain head written back by the data table.
interface head_table_if
  import ht_cfg_pkg::*;
();

  logic                    wr_en;
  logic [BUCKET_WIDTH-1:0] wr_bucket;
  logic [PTR_WIDTH-1:0]    wr_head_ptr;
  logic                    wr_head_val;

  modport master (
    output wr_en, wr_bucket, wr_head_ptr, wr_head_val
  );

  modport slave (
    input  wr_en, wr_bucket, wr_head_ptr, wr_head_val
  );

endinterface

/* common/ht_ops_pkg.sv */
package ht_ops_pkg;

  typedef enum logic {
    OP_SEARCH,
    OP_INSERT
  } ht_opcode_t;

  typedef enum logic [2:0] {
    RES_FOUND,
    RES_NOT_FOUND,
    RES_INSERTED,
    RES_UPDATED,
    RES_FULL
  } ht_result_t;

  // Chain walker states of the data table.
  typedef enum logic [2:0] {
    IDLE,
    READ_HEAD,
    READ_NO_HEAD,
    KEY_MATCH,
    KEY_NO_MATCH_HAVE_NEXT_PTR,
    GOT_TAIL,
    WRITE,
    CLEAR
  } ht_data_table_state_t;

endpackage

/* data_table/data_table.sv */
`timescale 1ns/1ns

module data_table
  import ht_cfg_pkg::*, ht_ops_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,

  ht_if.slave          ht_in,
  ht_res_if.master     ht_res_out,

  head_table_if.master head_table_if,

  input  logic         clear_run_i,
  output logic         clear_done_o
);

  ht_data_table_state_t    state;
  ht_data_table_state_t    next_state;

  // Command under service.
  ht_opcode_t              cmd_opcode;
  logic [KEY_WIDTH-1:0]    cmd_key;
  logic [VALUE_WIDTH-1:0]  cmd_value;
  logic [BUCKET_WIDTH-1:0] cmd_bucket;
  logic [PTR_WIDTH-1:0]    cmd_head_ptr;
  logic                    cmd_head_val;

  logic [PTR_WIDTH-1:0]    cur_ptr;
  logic [PTR_WIDTH:0]      free_cnt;
  logic                    table_full;
  logic [BUCKET_WIDTH-1:0] clear_cnt;

  ht_entry_t               rd_data;
  ht_entry_t               wr_data;
  logic [PTR_WIDTH-1:0]    rd_addr;
  logic [PTR_WIDTH-1:0]    wr_addr;
  logic                    wr_en;

  logic                    in_fire;
  logic                    comparing;
  logic                    key_match;
  logic                    hop;
  logic                    finish;

  logic                    res_valid;
  ht_result_t              res_result;
  logic [VALUE_WIDTH-1:0]  res_value;

  assign ht_in.ready = (state == IDLE) && !res_valid && !clear_run_i;
  assign in_fire     = ht_in.valid && ht_in.ready;
  assign table_full  = free_cnt[PTR_WIDTH];

  assign comparing = (state == READ_HEAD) || (state == KEY_NO_MATCH_HAVE_NEXT_PTR);
  assign key_match = (rd_data.key == cmd_key);
  assign hop       = comparing && (next_state == KEY_NO_MATCH_HAVE_NEXT_PTR);
  assign finish    = (next_state == IDLE) && (state != IDLE) && (state != CLEAR);

  // ----------------------------------------------------------------------
  // Chain walk.
  // ----------------------------------------------------------------------
  always_comb
    begin
      next_state = state;
      case (state)
        IDLE:
          if (in_fire)
            begin
              if (ht_in.head_ptr_val)
                next_state = READ_HEAD;
              else
                next_state = READ_NO_HEAD;
            end
        READ_HEAD, KEY_NO_MATCH_HAVE_NEXT_PTR:
          if (key_match)
            next_state = KEY_MATCH;
          else if (rd_data.next_ptr_val)
            next_state = KEY_NO_MATCH_HAVE_NEXT_PTR;
          else
            next_state = GOT_TAIL;
        KEY_MATCH:
          if (cmd_opcode == OP_INSERT)
            next_state = WRITE;
          else
            next_state = IDLE;
        READ_NO_HEAD, GOT_TAIL:
          if (cmd_opcode == OP_INSERT && !table_full)
            next_state = WRITE;
          else
            next_state = IDLE;
        WRITE:
          next_state = IDLE;
        CLEAR:
          if (clear_cnt == '1)
            next_state = IDLE;
        default:
          next_state = IDLE;
      endcase
      if (clear_run_i)
        next_state = CLEAR;
    end

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      state <= IDLE;
    else
      state <= next_state;

  // Keep reading the current entry unless the walk moves on.
  always_comb
    if (state == IDLE)
      rd_addr = ht_in.head_ptr;
    else if (hop)
      rd_addr = rd_data.next_ptr;
    else
      rd_addr = cur_ptr;

  always_ff @(posedge clk_i)
    if (in_fire)
      begin
        cmd_opcode   <= ht_in.opcode;
        cmd_key      <= ht_in.key;
        cmd_value    <= ht_in.value;
        cmd_bucket   <= ht_in.bucket;
        cmd_head_ptr <= ht_in.head_ptr;
        cmd_head_val <= ht_in.head_ptr_val;
        cur_ptr      <= ht_in.head_ptr;
      end
    else if (hop)
      cur_ptr <= rd_data.next_ptr;

  // ----------------------------------------------------------------------
  // Result.
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i)
    case (state)
      KEY_MATCH:
        if (cmd_opcode == OP_INSERT)
          begin
            res_result <= RES_UPDATED;
            res_value  <= cmd_value;
          end
        else
          begin
            res_result <= RES_FOUND;
            res_value  <= rd_data.value;
          end
      READ_NO_HEAD, GOT_TAIL:
        if (cmd_opcode == OP_SEARCH)
          begin
            res_result <= RES_NOT_FOUND;
            res_value  <= '0;
          end
        else if (table_full)
          begin
            res_result <= RES_FULL;
            res_value  <= '0;
          end
        else
          begin
            res_result <= RES_INSERTED;
            res_value  <= cmd_value;
          end
      default:
        ;
    endcase

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      res_valid <= 1'b0;
    else if (res_valid && ht_res_out.ready)
      res_valid <= 1'b0;
    else if (finish)
      res_valid <= 1'b1;

  assign ht_res_out.valid  = res_valid;
  assign ht_res_out.result = res_result;
  assign ht_res_out.key    = cmd_key;
  assign ht_res_out.value  = res_value;

  // ----------------------------------------------------------------------
  // Writes, allocation and clear.
  // ----------------------------------------------------------------------
  always_comb
    begin
      wr_data = rd_data;
      wr_addr = cur_ptr;
      wr_en   = (state == WRITE);
      if (state == CLEAR)
        begin
          wr_data = '0;
          wr_addr = clear_cnt[PTR_WIDTH-1:0];
          wr_en   = 1'b1;
        end
      else if (res_result == RES_UPDATED)
        wr_data.value = cmd_value;
      else
        begin
          // New entry becomes the head and links to the old one.
          wr_data = '{cmd_key, cmd_value, cmd_head_ptr, cmd_head_val};
          wr_addr = free_cnt[PTR_WIDTH-1:0];
        end
    end

  assign head_table_if.wr_en       = (state == WRITE) && (res_result == RES_INSERTED);
  assign head_table_if.wr_bucket   = cmd_bucket;
  assign head_table_if.wr_head_ptr = free_cnt[PTR_WIDTH-1:0];
  assign head_table_if.wr_head_val = 1'b1;

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      begin
        free_cnt  <= '0;
        clear_cnt <= '0;
      end
    else if (clear_run_i)
      clear_cnt <= '0;
    else if (state == CLEAR)
      begin
        clear_cnt <= clear_cnt + 1'b1;
        if (clear_done_o)
          free_cnt <= '0;
      end
    else if (head_table_if.wr_en)
      free_cnt <= free_cnt + 1'b1;

  assign clear_done_o = (state == CLEAR) && (clear_cnt == '1);

  ht_true_dp_ram #(
    .DATA_WIDTH ( ENTRY_WIDTH          ),
    .ADDR_WIDTH ( PTR_WIDTH            )
  ) u_data_ram (
    .clk_i      ( clk_i                ),

    .addr_a_i   ( rd_addr              ),
    .data_a_i   ( {ENTRY_WIDTH{1'b0}}  ),
    .we_a_i     ( 1'b0                 ),
    .q_a_o      ( rd_data              ),

    .addr_b_i   ( wr_addr              ),
    .data_b_i   ( wr_data              ),
    .we_b_i     ( wr_en                ),
    .q_b_o      (                      )
  );

endmodule

/* files.f */
common/ht_cfg_pkg.sv
common/ht_ops_pkg.sv
common/ht_ifs.sv
hw/ht_true_dp_ram.sv
hw/ht_hash.sv
head_table/head_table.sv
data_table/data_table.sv
hw/ht_top.sv
tests/ht_tb.sv

/* head_table/head_table.sv */
`timescale 1ns/1ns

module head_table
  import ht_cfg_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,

  ht_if.slave          ht_in,
  ht_if.master         ht_out,

  head_table_if.slave  head_table_if,

  input  logic         clear_run_i,
  output logic         clear_busy_o
);

  logic [HEAD_WIDTH-1:0]   head_rd;
  logic [HEAD_WIDTH-1:0]   head_upd;
  logic [HEAD_WIDTH-1:0]   head_held;
  logic                    head_from_ram;

  logic                    in_fire;
  logic                    fwd_in;
  logic                    fwd_out;

  logic [BUCKET_WIDTH-1:0] clear_addr;
  logic [BUCKET_WIDTH-1:0] wr_addr;
  logic [HEAD_WIDTH-1:0]   wr_data;
  logic                    wr_en;

  assign ht_in.ready = !clear_run_i && !clear_busy_o && (!ht_out.valid || ht_out.ready);
  assign in_fire     = ht_in.valid && ht_in.ready;

  assign head_upd = {head_table_if.wr_head_ptr, head_table_if.wr_head_val};
  assign fwd_in   = head_table_if.wr_en && (head_table_if.wr_bucket == ht_in.bucket);
  assign fwd_out  = head_table_if.wr_en && (head_table_if.wr_bucket == ht_out.bucket);

  // ----------------------------------------------------------------------
  // Output stage.
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      begin
        ht_out.valid  <= 1'b0;
        head_from_ram <= 1'b0;
      end
    else
      begin
        if (in_fire)
          ht_out.valid <= 1'b1;
        else if (ht_out.ready)
          ht_out.valid <= 1'b0;
        // RAM data is good for one cycle only unless a write beat it.
        head_from_ram <= in_fire && !fwd_in;
      end

  always_ff @(posedge clk_i)
    if (in_fire)
      begin
        ht_out.opcode <= ht_in.opcode;
        ht_out.key    <= ht_in.key;
        ht_out.value  <= ht_in.value;
        ht_out.bucket <= ht_in.bucket;
      end

  // Held head follows late writes to the same bucket.
  always_ff @(posedge clk_i)
    if (in_fire || fwd_out)
      head_held <= head_upd;
    else if (head_from_ram)
      head_held <= head_rd;

  assign ht_out.head_ptr     = head_from_ram ? head_rd[HEAD_WIDTH-1:1] : head_held[HEAD_WIDTH-1:1];
  assign ht_out.head_ptr_val = head_from_ram ? head_rd[0] : head_held[0];

  // ----------------------------------------------------------------------
  // Clear sequencer steps one bucket per cycle.
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      begin
        clear_busy_o <= 1'b0;
        clear_addr   <= '0;
      end
    else if (clear_run_i)
      begin
        clear_busy_o <= 1'b1;
        clear_addr   <= '0;
      end
    else if (clear_busy_o)
      begin
        clear_addr <= clear_addr + 1'b1;
        if (clear_addr == '1)
          clear_busy_o <= 1'b0;
      end

  assign wr_addr = clear_busy_o ? clear_addr : head_table_if.wr_bucket;
  assign wr_data = clear_busy_o ? '0 : head_upd;
  assign wr_en   = clear_busy_o || head_table_if.wr_en;

  ht_true_dp_ram #(
    .DATA_WIDTH ( HEAD_WIDTH          ),
    .ADDR_WIDTH ( BUCKET_WIDTH        )
  ) u_head_ram (
    .clk_i      ( clk_i               ),

    .addr_a_i   ( ht_in.bucket        ),
    .data_a_i   ( {HEAD_WIDTH{1'b0}}  ),
    .we_a_i     ( 1'b0                ),
    .q_a_o      ( head_rd             ),

    .addr_b_i   ( wr_addr             ),
    .data_b_i   ( wr_data             ),
    .we_b_i     ( wr_en               ),
    .q_b_o      (                     )
  );

endmodule

/* hw/ht_hash.sv */
`timescale 1ns/1ns

module ht_hash
  import ht_cfg_pkg::*, ht_ops_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,

  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  ht_opcode_t             cmd_opcode_i,
  input  logic [KEY_WIDTH-1:0]   cmd_key_i,
  input  logic [VALUE_WIDTH-1:0] cmd_value_i,

  ht_if.master                   ht_out
);

  logic cmd_fire;

  // XOR of all bucket-sized slices of the key.
  function automatic logic [BUCKET_WIDTH-1:0] fold_key(input logic [KEY_WIDTH-1:0] key);
    logic [BUCKET_WIDTH-1:0] acc;
    acc = '0;
    for (int i = 0; i < KEY_WIDTH / BUCKET_WIDTH; i++)
      acc ^= key[i*BUCKET_WIDTH +: BUCKET_WIDTH];
    return acc;
  endfunction

  assign cmd_ready_o = !ht_out.valid || ht_out.ready;
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      ht_out.valid <= 1'b0;
    else if (cmd_fire)
      ht_out.valid <= 1'b1;
    else if (ht_out.ready)
      ht_out.valid <= 1'b0;

  always_ff @(posedge clk_i)
    if (cmd_fire)
      begin
        ht_out.opcode <= cmd_opcode_i;
        ht_out.key    <= cmd_key_i;
        ht_out.value  <= cmd_value_i;
        ht_out.bucket <= fold_key(cmd_key_i);
      end

  // Head is looked up by the next stage.
  assign ht_out.head_ptr     = '0;
  assign ht_out.head_ptr_val = 1'b0;

endmodule

/* hw/ht_top.sv */
`timescale 1ns/1ns

module ht_top
  import ht_cfg_pkg::*, ht_ops_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,

  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  ht_opcode_t             cmd_opcode_i,
  input  logic [KEY_WIDTH-1:0]   cmd_key_i,
  input  logic [VALUE_WIDTH-1:0] cmd_value_i,

  output logic                   res_valid_o,
  input  logic                   res_ready_i,
  output ht_result_t             res_result_o,
  output logic [KEY_WIDTH-1:0]   res_key_o,
  output logic [VALUE_WIDTH-1:0] res_value_o,

  input  logic                   clear_run_i,
  output logic                   clear_done_o
);

  ht_if         hash_to_head ();
  ht_if         head_to_data ();
  ht_res_if     res_if ();
  head_table_if head_upd ();

  assign res_valid_o  = res_if.valid;
  assign res_result_o = res_if.result;
  assign res_key_o    = res_if.key;
  assign res_value_o  = res_if.value;
  assign res_if.ready = res_ready_i;

  ht_hash u_hash (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),

    .cmd_valid_i   ( cmd_valid_i   ),
    .cmd_ready_o   ( cmd_ready_o   ),
    .cmd_opcode_i  ( cmd_opcode_i  ),
    .cmd_key_i     ( cmd_key_i     ),
    .cmd_value_i   ( cmd_value_i   ),

    .ht_out        ( hash_to_head  )
  );

  // Busy flag stays internal to the head table.
  head_table u_head_table (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),

    .ht_in         ( hash_to_head  ),
    .ht_out        ( head_to_data  ),

    .head_table_if ( head_upd      ),

    .clear_run_i   ( clear_run_i   ),
    .clear_busy_o  (               )
  );

  data_table u_data_table (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),

    .ht_in         ( head_to_data  ),
    .ht_res_out    ( res_if        ),

    .head_table_if ( head_upd      ),

    .clear_run_i   ( clear_run_i   ),
    .clear_done_o  ( clear_done_o  )
  );

endmodule

/* hw/ht_true_dp_ram.sv */
`timescale 1ns/1ns

module ht_true_dp_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
)
(
  input  logic                  clk_i,

  input  logic [ADDR_WIDTH-1:0] addr_a_i,
  input  logic [DATA_WIDTH-1:0] data_a_i,
  input  logic                  we_a_i,
  output logic [DATA_WIDTH-1:0] q_a_o,

  input  logic [ADDR_WIDTH-1:0] addr_b_i,
  input  logic [DATA_WIDTH-1:0] data_b_i,
  input  logic                  we_b_i,
  output logic [DATA_WIDTH-1:0] q_b_o
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // Read-first on both ports. Port B wins on a write collision.
  always_ff @(posedge clk_i)
    begin
      if (we_a_i)
        mem[addr_a_i] <= data_a_i;
      if (we_b_i)
        mem[addr_b_i] <= data_b_i;
      q_a_o <= mem[addr_a_i];
      q_b_o <= mem[addr_b_i];
    end

endmodule

/* tests/ht_input.txt */
# op      key       value  result     exp_value
# exp_value is compared for FOUND results only.
SEARCH    12345678  0000   NOT_FOUND  0000
SEARCH    deadbeef  0000   NOT_FOUND  0000
INSERT    12345678  1111   INSERTED   1111
SEARCH    12345678  0000   FOUND      1111
INSERT    00000001  aaaa   INSERTED   aaaa
INSERT    00000100  bbbb   INSERTED   bbbb
INSERT    00010000  cccc   INSERTED   cccc
INSERT    01000000  dddd   INSERTED   dddd
SEARCH    00000001  0000   FOUND      aaaa
SEARCH    00000100  0000   FOUND      bbbb
SEARCH    00010000  0000   FOUND      cccc
SEARCH    01000000  0000   FOUND      dddd
SEARCH    02000003  0000   NOT_FOUND  0000
INSERT    00000100  0bb1   UPDATED    0bb1
SEARCH    00000100  0000   FOUND      0bb1
SEARCH    00000001  0000   FOUND      aaaa
INSERT    a0000001  0a01   INSERTED   0a01
INSERT    a0000002  0a02   INSERTED   0a02
INSERT    a0000003  0a03   INSERTED   0a03
INSERT    a0000004  0a04   INSERTED   0a04
INSERT    a0000005  0a05   INSERTED   0a05
INSERT    a0000006  0a06   INSERTED   0a06
INSERT    a0000007  0a07   INSERTED   0a07
INSERT    a0000008  0a08   INSERTED   0a08
INSERT    a0000009  0a09   INSERTED   0a09
INSERT    a000000a  0a0a   INSERTED   0a0a
INSERT    a000000b  0a0b   INSERTED   0a0b
INSERT    b0000000  ffff   FULL       0000
SEARCH    b0000000  0000   NOT_FOUND  0000
INSERT    a0000005  5555   UPDATED    5555
SEARCH    a0000005  0000   FOUND      5555
SEARCH    12345678  0000   FOUND      1111
CLEAR     00000000  0000   NONE       0000
SEARCH    12345678  0000   NOT_FOUND  0000
SEARCH    00000100  0000   NOT_FOUND  0000
SEARCH    a0000005  0000   NOT_FOUND  0000
INSERT    c0000000  0c00   INSERTED   0c00
INSERT    c0000001  0c01   INSERTED   0c01
INSERT    c0000002  0c02   INSERTED   0c02
INSERT    c0000003  0c03   INSERTED   0c03
INSERT    c0000004  0c04   INSERTED   0c04
INSERT    c0000005  0c05   INSERTED   0c05
INSERT    c0000006  0c06   INSERTED   0c06
INSERT    c0000007  0c07   INSERTED   0c07
INSERT    c0000008  0c08   INSERTED   0c08
INSERT    c0000009  0c09   INSERTED   0c09
INSERT    c000000a  0c0a   INSERTED   0c0a
INSERT    c000000b  0c0b   INSERTED   0c0b
INSERT    c000000c  0c0c   INSERTED   0c0c
INSERT    c000000d  0c0d   INSERTED   0c0d
INSERT    c000000e  0c0e   INSERTED   0c0e
INSERT    c000000f  0c0f   INSERTED   0c0f
SEARCH    c0000000  0000   FOUND      0c00
SEARCH    c000000f  0000   FOUND      0c0f
INSERT    d0000000  1234   FULL       0000

/* tests/ht_tb.sv */
`timescale 1ns/1ns

module ht_tb
  import ht_cfg_pkg::*, ht_ops_pkg::*;
();

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 4;
  localparam int CMD_TIMEOUT   = 200;
  localparam int RES_TIMEOUT   = 2000;
  localparam int CLEAR_TIMEOUT = 400;

  typedef struct packed {
    ht_result_t             result;
    logic [KEY_WIDTH-1:0]   key;
    logic [VALUE_WIDTH-1:0] value;
  } expected_t;

  logic                   clk;
  logic                   rst;
  logic                   cmd_valid;
  logic                   cmd_ready;
  ht_opcode_t             cmd_opcode;
  logic [KEY_WIDTH-1:0]   cmd_key;
  logic [VALUE_WIDTH-1:0] cmd_value;
  logic                   res_valid;
  logic                   res_ready;
  ht_result_t             res_result;
  logic [KEY_WIDTH-1:0]   res_key;
  logic [VALUE_WIDTH-1:0] res_value;
  logic                   clear_run;
  logic                   clear_done;

  integer                 seed;

  // Commands as read from the data file.
  logic                   line_clear [$];
  ht_opcode_t             line_op    [$];
  logic [KEY_WIDTH-1:0]   line_key   [$];
  logic [VALUE_WIDTH-1:0] line_value [$];
  expected_t              line_exp   [$];

  // Results still owed by the DUT, oldest first.
  expected_t              pending    [$];

  ht_top u_dut (
    .clk_i        ( clk        ),
    .rst_i        ( rst        ),
    .cmd_valid_i  ( cmd_valid  ),
    .cmd_ready_o  ( cmd_ready  ),
    .cmd_opcode_i ( cmd_opcode ),
    .cmd_key_i    ( cmd_key    ),
    .cmd_value_i  ( cmd_value  ),
    .res_valid_o  ( res_valid  ),
    .res_ready_i  ( res_ready  ),
    .res_result_o ( res_result ),
    .res_key_o    ( res_key    ),
    .res_value_o  ( res_value  ),
    .clear_run_i  ( clear_run  ),
    .clear_done_o ( clear_done )
  );

  initial
    begin
      clk = 1'b0;
      forever
        #(CLK_PERIOD / 2) clk = ~clk;
    end

  // --------------------------------------------------------------------
  // Failure reporting and checks.
  // --------------------------------------------------------------------
  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic report_mismatch(input string what);
    $display("[FAIL] %0t ns: %s", $time, what);
    abort_run();
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s.", what);
    abort_run();
  endtask

  task automatic check_result(input ht_result_t got, input ht_result_t want);
    if (got !== want)
      report_mismatch($sformatf("result %s, expected %s", got.name(), want.name()));
  endtask

  task automatic check_value(input logic [VALUE_WIDTH-1:0] got,
                             input logic [VALUE_WIDTH-1:0] want);
    if (got !== want)
      report_mismatch($sformatf("value %h, expected %h", got, want));
  endtask

  task automatic check_key(input logic [KEY_WIDTH-1:0] got,
                           input logic [KEY_WIDTH-1:0] want);
    if (got !== want)
      report_mismatch($sformatf("key %h, expected %h", got, want));
  endtask

  // --------------------------------------------------------------------
  // Data file.
  // --------------------------------------------------------------------
  task automatic parse_result(input logic [8*16-1:0] word, output ht_result_t result);
    result = RES_NOT_FOUND;
    case (word)
      "FOUND":
        result = RES_FOUND;
      "NOT_FOUND":
        result = RES_NOT_FOUND;
      "INSERTED":
        result = RES_INSERTED;
      "UPDATED":
        result = RES_UPDATED;
      "FULL":
        result = RES_FULL;
      default:
        begin
          $display("Unknown result word in the data file.");
          abort_run();
        end
    endcase
  endtask

  task automatic load_commands();
    integer                 fd;
    integer                 code;
    int                     ch;
    logic                   done;
    logic [8*16-1:0]        op_word;
    logic [8*16-1:0]        res_word;
    logic [KEY_WIDTH-1:0]   key;
    logic [VALUE_WIDTH-1:0] value;
    logic [VALUE_WIDTH-1:0] exp_value;
    ht_result_t             exp_result;
    expected_t              item;
    fd = $fopen("tests/ht_input.txt", "r");
    if (fd == 0)
      begin
        $display("Could not open the data file tests/ht_input.txt.");
        abort_run();
      end
    done = 1'b0;
    while (!done)
      begin
        op_word = '0;
        code    = $fscanf(fd, "%s", op_word);
        if (code != 1)
          done = 1'b1;
        else if (op_word == "#")
          begin
            // Rest of a comment line.
            ch = $fgetc(fd);
            while (ch != 10 && ch != -1)
              ch = $fgetc(fd);
          end
        else
          begin
            res_word = '0;
            code     = $fscanf(fd, "%h %h %s %h", key, value, res_word, exp_value);
            if (code != 4 || !(op_word == "SEARCH" || op_word == "INSERT" ||
                               op_word == "CLEAR"))
              begin
                $display("Malformed line in the data file.");
                abort_run();
              end
            item = '0;
            if (op_word != "CLEAR")
              begin
                parse_result(res_word, exp_result);
                item.result = exp_result;
                item.key    = key;
                item.value  = exp_value;
              end
            line_clear.push_back(op_word == "CLEAR");
            line_op.push_back(op_word == "INSERT" ? OP_INSERT : OP_SEARCH);
            line_key.push_back(key);
            line_value.push_back(value);
            line_exp.push_back(item);
          end
      end
    $fclose(fd);
  endtask

  // --------------------------------------------------------------------
  // Stimulus. Each task starts and ends just after a rising edge.
  // --------------------------------------------------------------------
  task automatic send_command(input ht_opcode_t op, input logic [KEY_WIDTH-1:0] key,
                              input logic [VALUE_WIDTH-1:0] value);
    int   waited;
    logic taken;
    cmd_valid  <= 1'b1;
    cmd_opcode <= op;
    cmd_key    <= key;
    cmd_value  <= value;
    waited = 0;
    taken  = 1'b0;
    while (!taken)
      begin
        @(negedge clk);
        taken = cmd_ready;
        @(posedge clk);
        waited++;
        if (!taken && waited > CMD_TIMEOUT)
          report_timeout("the command handshake");
      end
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (pending.size() != 0)
      begin
        @(posedge clk);
        waited++;
        if (waited > RES_TIMEOUT)
          report_timeout("the outstanding results");
      end
  endtask

  task automatic run_clear();
    int   waited;
    logic done;
    clear_run <= 1'b1;
    @(posedge clk);
    clear_run <= 1'b0;
    waited = 0;
    done   = 1'b0;
    while (!done)
      begin
        @(negedge clk);
        done = clear_done;
        waited++;
        if (!done && waited > CLEAR_TIMEOUT)
          report_timeout("clear_done_o");
      end
    @(negedge clk);
    if (clear_done !== 1'b0)
      report_mismatch("clear_done_o high for more than one cycle");
    @(posedge clk);
  endtask

  // Random back-pressure on the result port.
  initial
    begin
      seed = 32'hdf8ea779;
      res_ready <= 1'b0;
      forever
        begin
          @(posedge clk);
          res_ready <= ($random(seed) & 32'd3) != 32'd0;
        end
    end

  // Results are compared in command order.
  initial
    begin : result_monitor
      expected_t want;
      forever
        begin
          @(negedge clk);
          if (res_valid && res_ready)
            begin
              if (pending.size() == 0)
                begin
                  $display("A result arrived with no command outstanding.");
                  abort_run();
                end
              else
                begin
                  want = pending.pop_front();
                  check_result(res_result, want.result);
                  check_key(res_key, want.key);
                  // Only a hit carries a stored value.
                  if (want.result == RES_FOUND)
                    check_value(res_value, want.value);
                end
            end
        end
    end

  initial
    begin : main_sequence
      int idx;
      rst        <= 1'b1;
      cmd_valid  <= 1'b0;
      cmd_opcode <= OP_SEARCH;
      cmd_key    <= '0;
      cmd_value  <= '0;
      clear_run  <= 1'b0;
      load_commands();
      repeat (RESET_CYCLES)
        @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      // Both memories are undefined until the first clear.
      run_clear();
      for (idx = 0; idx < line_op.size(); idx++)
        begin
          if (line_clear[idx])
            begin
              cmd_valid <= 1'b0;
              wait_for_drain();
              run_clear();
            end
          else
            begin
              pending.push_back(line_exp[idx]);
              send_command(line_op[idx], line_key[idx], line_value[idx]);
            end
        end
      cmd_valid <= 1'b0;
      wait_for_drain();
      $display("No errors");
      $finish;
    end

endmodule
